// File: rtl/credit_counter_settings.svh
`ifndef CREDIT_COUNTER_SETTINGS_SVH
`define CREDIT_COUNTER_SETTINGS_SVH

// router geometry
`define CC_PORTS 5      // router ports, local port included
`define CC_VCS 4        // virtual channels per port

// downstream input buffer size seen by each output VC
`define CC_BUF_DEPTH 4  // flit slots per OVC

// derived sizes
`define CC_OVCS (`CC_PORTS * `CC_VCS)
`define CC_CREDIT_W $clog2(`CC_BUF_DEPTH + 1)

`endif

// File: rtl/credit_counter_pkg.sv
`include "credit_counter_settings.svh"

package credit_counter_pkg;

    typedef logic [`CC_OVCS-1:0] ovc_vec_t;         // one bit per OVC, port major
    typedef logic [`CC_VCS-1:0] vc_onehot_t;        // VC select inside one port
    typedef logic [`CC_PORTS-2:0] other_port_onehot_t; // own port skipped
    typedef logic [`CC_CREDIT_W-1:0] credit_t;      // 0 .. buffer depth

    typedef enum logic {
        ovc_free = 1'b0,
        ovc_busy = 1'b1
    } ovc_state_e;

    // grant of one input port as seen after the first switch arbiter
    typedef struct packed {
        vc_onehot_t granted_ivc;
        other_port_onehot_t granted_dest;
        vc_onehot_t tail;                        // head VC flit is a tail
        vc_onehot_t assigned;                    // VC holds an OVC
        vc_onehot_t [`CC_VCS-1:0] assigned_ovc;  // OVC held by each VC
    } port_grant_t;

    typedef struct packed {
        ovc_vec_t taken_by;  // one credit used
        ovc_vec_t released;  // tail left, OVC back to free
    } ovc_event_t;

    // index among the other ports to absolute port number
    function automatic int other_to_abs(int src_port, int other_idx);
        return (other_idx < src_port) ? other_idx : other_idx + 1;
    endfunction

endpackage

// File: rtl/inport_grant_decode.sv
`include "credit_counter_settings.svh"

module inport_grant_decode #(
    parameter int SRC_PORT = 0
) (
    input  credit_counter_pkg::port_grant_t grant,
    output credit_counter_pkg::ovc_event_t  ovc_event
);

    credit_counter_pkg::vc_onehot_t sel_ovc;  // OVC of the granted input VC
    logic                           sel_tail;
    credit_counter_pkg::ovc_vec_t   taken;

    // pick the OVC and tail flag of the granted VC
    always_comb begin
        sel_ovc  = '0;
        sel_tail = 1'b0;
        for (int v = 0; v < `CC_VCS; v++) begin
            if (grant.granted_ivc[v] && grant.assigned[v]) begin  // unassigned VCs give nothing
                sel_ovc  = sel_ovc | grant.assigned_ovc[v];
                sel_tail = sel_tail | grant.tail[v];
            end
        end
    end

    // drop the OVC onto the granted output port
    always_comb begin : place_blk
        int abs_port;
        taken = '0;
        for (int d = 0; d < `CC_PORTS - 1; d++) begin
            abs_port = credit_counter_pkg::other_to_abs(SRC_PORT, d);
            if (grant.granted_dest[d]) begin
                taken[abs_port*`CC_VCS +: `CC_VCS] = sel_ovc;
            end
        end
    end

    assign ovc_event.taken_by = taken;
    assign ovc_event.released = sel_tail ? taken : '0;  // tail frees the OVC it used

endmodule

// File: rtl/ovc_credit_table.sv
`include "credit_counter_settings.svh"

module ovc_credit_table (
    input  logic                           clk,
    input  logic                           reset,
    input  credit_counter_pkg::ovc_event_t ovc_event,
    input  credit_counter_pkg::ovc_vec_t   allocated,
    input  credit_counter_pkg::ovc_vec_t   credit_in,
    output credit_counter_pkg::ovc_vec_t   ovc_available,
    output credit_counter_pkg::ovc_vec_t   full,
    output credit_counter_pkg::ovc_vec_t   nearly_full
);

    localparam credit_counter_pkg::credit_t DEPTH =
        credit_counter_pkg::credit_t'(`CC_BUF_DEPTH);
    localparam credit_counter_pkg::credit_t ONE = credit_counter_pkg::credit_t'(1);

    credit_counter_pkg::credit_t    credit      [`CC_OVCS];
    credit_counter_pkg::credit_t    credit_next [`CC_OVCS];
    credit_counter_pkg::ovc_state_e state       [`CC_OVCS];
    credit_counter_pkg::ovc_vec_t   decrease;   // flit sent or OVC allocated
    credit_counter_pkg::ovc_vec_t   busy;

    assign decrease = ovc_event.taken_by | allocated;

    // up on returned credit, down on use, both cancel
    always_comb begin
        for (int k = 0; k < `CC_OVCS; k++) begin
            credit_next[k] = credit[k];
            if (credit_in[k] && !decrease[k]) begin
                credit_next[k] = credit[k] + ONE;
            end else if (!credit_in[k] && decrease[k]) begin
                credit_next[k] = credit[k] - ONE;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `CC_OVCS; k++) begin
                credit[k] <= DEPTH;
                state[k]  <= credit_counter_pkg::ovc_free;
            end
            full        <= '0;
            nearly_full <= '0;
        end else begin
            for (int k = 0; k < `CC_OVCS; k++) begin
                credit[k]      <= credit_next[k];
                full[k]        <= (credit_next[k] == '0);
                nearly_full[k] <= (credit_next[k] <= ONE);  // last slot in use
                if (ovc_event.released[k]) begin
                    state[k] <= credit_counter_pkg::ovc_free;
                end
                if (allocated[k]) begin
                    state[k] <= credit_counter_pkg::ovc_busy;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `CC_OVCS; k++) begin
            busy[k] = (state[k] == credit_counter_pkg::ovc_busy);
        end
    end

    // non-atomic reuse: a free OVC may be handed out before it drains
    assign ovc_available = ~(busy | nearly_full);

    for (genvar k = 0; k < `CC_OVCS; k++) begin : g_chk
        a_credit_overflow : assert property (
            @(posedge clk) disable iff (reset)
            credit_in[k] |-> (credit[k] < DEPTH)
        ) else $error("credit returned to empty OVC %0d", k);

        a_send_when_full : assert property (
            @(posedge clk) disable iff (reset)
            decrease[k] |-> (credit[k] != '0)
        ) else $error("flit sent to OVC %0d with no credit", k);

        a_alloc_and_release : assert property (
            @(posedge clk) disable iff (reset)
            !(allocated[k] && ovc_event.released[k])
        ) else $error("OVC %0d allocated and released together", k);

        a_release_free : assert property (
            @(posedge clk) disable iff (reset)
            ovc_event.released[k] |-> (state[k] == credit_counter_pkg::ovc_busy)
        ) else $error("release of free OVC %0d", k);

        a_alloc_busy : assert property (
            @(posedge clk) disable iff (reset)
            allocated[k] |-> (state[k] == credit_counter_pkg::ovc_free)
        ) else $error("allocation of busy OVC %0d", k);
    end

endmodule

// File: rtl/assigned_ovc_full_check.sv
`include "credit_counter_settings.svh"

module assigned_ovc_full_check #(
    parameter int SRC_PORT = 0
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  credit_counter_pkg::ovc_vec_t           full,
    input  credit_counter_pkg::ovc_vec_t           nearly_full,
    input  credit_counter_pkg::ovc_vec_t           credit_in,
    input  credit_counter_pkg::vc_onehot_t         assigned_ovc_num,
    input  credit_counter_pkg::other_port_onehot_t dest_port,
    input  logic                                   sw_grant,
    output logic                                   not_full
);

    credit_counter_pkg::vc_onehot_t port_full;    // flags of the destination port
    credit_counter_pkg::vc_onehot_t port_nearly;
    logic                           sel_full;
    logic                           sel_nearly;
    logic                           full_q;
    logic                           nearly_sent_q;  // last credit taken by our own send

    // flags of the destination port, a credit arriving now clears them
    always_comb begin : port_blk
        int abs_port;
        port_full   = '0;
        port_nearly = '0;
        for (int d = 0; d < `CC_PORTS - 1; d++) begin
            abs_port = credit_counter_pkg::other_to_abs(SRC_PORT, d);
            if (dest_port[d]) begin
                port_full   = port_full |
                    (full[abs_port*`CC_VCS +: `CC_VCS] &
                     ~credit_in[abs_port*`CC_VCS +: `CC_VCS]);
                port_nearly = port_nearly |
                    (nearly_full[abs_port*`CC_VCS +: `CC_VCS] &
                     ~credit_in[abs_port*`CC_VCS +: `CC_VCS]);
            end
        end
    end

    assign sel_full   = |(port_full & assigned_ovc_num);
    assign sel_nearly = |(port_nearly & assigned_ovc_num);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full_q        <= 1'b0;
            nearly_sent_q <= 1'b0;
        end else begin
            full_q        <= sel_full;
            nearly_sent_q <= sel_nearly & sw_grant;  // table sees this send one cycle late
        end
    end

    assign not_full = ~(full_q | nearly_sent_q);

endmodule

// File: rtl/credit_counter_top.sv
`include "credit_counter_settings.svh"

module credit_counter_top (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  credit_counter_pkg::port_grant_t [`CC_PORTS-1:0]      grant,
    input  credit_counter_pkg::ovc_vec_t                         allocated,
    input  credit_counter_pkg::ovc_vec_t                         credit_in,
    input  credit_counter_pkg::ovc_vec_t                         sw_grant_ivc,
    input  credit_counter_pkg::vc_onehot_t [`CC_OVCS-1:0]        assigned_ovc_num,
    input  credit_counter_pkg::other_port_onehot_t [`CC_OVCS-1:0] dest_port,
    output credit_counter_pkg::ovc_vec_t                         ovc_available,
    output credit_counter_pkg::ovc_vec_t                         assigned_ovc_not_full
);

    credit_counter_pkg::ovc_event_t port_event [`CC_PORTS];  // one per input port
    credit_counter_pkg::ovc_event_t merged_event;
    credit_counter_pkg::ovc_vec_t   full;
    credit_counter_pkg::ovc_vec_t   nearly_full;

    for (genvar p = 0; p < `CC_PORTS; p++) begin : g_port
        inport_grant_decode #(
            .SRC_PORT (p)
        ) u_inport_grant_decode (
            .grant     (grant[p]),
            .ovc_event (port_event[p])
        );
    end

    // an OVC is reached from at most one input port per cycle
    always_comb begin
        merged_event = '0;
        for (int p = 0; p < `CC_PORTS; p++) begin
            merged_event.taken_by = merged_event.taken_by | port_event[p].taken_by;
            merged_event.released = merged_event.released | port_event[p].released;
        end
    end

    ovc_credit_table u_ovc_credit_table (
        .clk           (clk),
        .reset         (reset),
        .ovc_event     (merged_event),
        .allocated     (allocated),
        .credit_in     (credit_in),
        .ovc_available (ovc_available),
        .full          (full),
        .nearly_full   (nearly_full)
    );

    for (genvar i = 0; i < `CC_OVCS; i++) begin : g_ivc
        assigned_ovc_full_check #(
            .SRC_PORT (i / `CC_VCS)  // port owning this input VC
        ) u_assigned_ovc_full_check (
            .clk              (clk),
            .reset            (reset),
            .full             (full),
            .nearly_full      (nearly_full),
            .credit_in        (credit_in),
            .assigned_ovc_num (assigned_ovc_num[i]),
            .dest_port        (dest_port[i]),
            .sw_grant         (sw_grant_ivc[i]),
            .not_full         (assigned_ovc_not_full[i])
        );
    end

endmodule

// File: tests/credit_checker.sv
`include "credit_counter_settings.svh"

module credit_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  credit_counter_pkg::ovc_vec_t ovc_available,
    input  credit_counter_pkg::ovc_vec_t assigned_ovc_not_full,
    input  logic                         check_req,
    input  int                           check_id,
    input  credit_counter_pkg::ovc_vec_t exp_available,
    input  credit_counter_pkg::ovc_vec_t exp_not_full,
    output int                           checks_done,
    output int                           error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            checks_done <= 0;
            error_count <= 0;
        end else begin : cmp_blk
            int wrong;
            wrong = 0;
            if ($isunknown({ovc_available, assigned_ovc_not_full})) begin  // watch every cycle
                $display("ERROR at %0d ns: DUT outputs hold unknown bits, available %h not_full %h",
                         $time, ovc_available, assigned_ovc_not_full);
                wrong++;
            end
            if (check_req) begin
                if (ovc_available !== exp_available) begin
                    $display("ERROR at %0d ns: test %0d ovc_available is %h, expected %h",
                             $time, check_id, ovc_available, exp_available);
                    wrong++;
                end
                if (assigned_ovc_not_full !== exp_not_full) begin
                    $display("ERROR at %0d ns: test %0d assigned_ovc_not_full is %h, expected %h",
                             $time, check_id, assigned_ovc_not_full, exp_not_full);
                    wrong++;
                end
                if (wrong == 0) begin
                    $display("test %0d passed at %0d ns", check_id, $time);
                end else begin
                    $display("test %0d failed at %0d ns", check_id, $time);
                end
                checks_done <= checks_done + 1;
            end
            error_count <= error_count + wrong;
        end
    end

endmodule

// File: tests/tb_credit_counter.sv
`include "credit_counter_settings.svh"

module tb_credit_counter;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        op_alloc,
        op_send,
        op_send_tail,
        op_credit,
        op_idle
    } test_op_e;

    typedef credit_counter_pkg::port_grant_t [`CC_PORTS-1:0] grant_bus_t;

    localparam int CHECK_TIMEOUT = 50;  // cycles for the checker to answer

    logic                                                   clk;
    logic                                                   reset;
    grant_bus_t                                             grant;
    credit_counter_pkg::ovc_vec_t                           allocated;
    credit_counter_pkg::ovc_vec_t                           credit_in;
    credit_counter_pkg::ovc_vec_t                           sw_grant_ivc;
    credit_counter_pkg::vc_onehot_t [`CC_OVCS-1:0]          assigned_ovc_num;
    credit_counter_pkg::other_port_onehot_t [`CC_OVCS-1:0]  dest_port;
    credit_counter_pkg::ovc_vec_t                           ovc_available;
    credit_counter_pkg::ovc_vec_t                           assigned_ovc_not_full;

    logic                         check_req;
    int                           check_id;
    credit_counter_pkg::ovc_vec_t exp_available;
    credit_counter_pkg::ovc_vec_t exp_not_full;
    int                           checks_done;
    int                           error_count;

    int fd;
    int test_count;
    bit timed_out;
    bit bad_pattern;

    credit_counter_top u_credit_counter_top (
        .clk                   (clk),
        .reset                 (reset),
        .grant                 (grant),
        .allocated             (allocated),
        .credit_in             (credit_in),
        .sw_grant_ivc          (sw_grant_ivc),
        .assigned_ovc_num      (assigned_ovc_num),
        .dest_port             (dest_port),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

    credit_checker u_credit_checker (
        .clk                   (clk),
        .reset                 (reset),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .check_req             (check_req),
        .check_id              (check_id),
        .exp_available         (exp_available),
        .exp_not_full          (exp_not_full),
        .checks_done           (checks_done),
        .error_count           (error_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;  // 20 ns period
        end
    end

    // the input port that holds the OVC; always the next port up
    function automatic int source_port(input int p);
        return (p + 1) % `CC_PORTS;
    endfunction

    function automatic credit_counter_pkg::vc_onehot_t vc_onehot(input int v);
        credit_counter_pkg::vc_onehot_t r;
        r = '0;
        r[v] = 1'b1;
        return r;
    endfunction

    // destination as seen from port s, own port left out
    function automatic credit_counter_pkg::other_port_onehot_t dest_onehot(input int s,
                                                                           input int p);
        credit_counter_pkg::other_port_onehot_t r;
        r = '0;
        if (p < s) begin
            r[p] = 1'b1;
        end else begin
            r[p - 1] = 1'b1;
        end
        return r;
    endfunction

    function automatic bit parse_op(input string name, output test_op_e op);
        op = op_idle;
        if (name == "alloc") op = op_alloc;
        else if (name == "send") op = op_send;
        else if (name == "send_tail") op = op_send_tail;
        else if (name == "credit") op = op_credit;
        else if (name != "idle") return 1'b0;
        return 1'b1;
    endfunction

    // ties OVC (p, v) to the input VC v of its source port, or drops it
    task automatic set_route(input int p, input int v, input bit on, inout grant_bus_t g);
        credit_counter_pkg::vc_onehot_t [`CC_OVCS-1:0]         num_next;
        credit_counter_pkg::other_port_onehot_t [`CC_OVCS-1:0] dest_next;
        int                                                    s;
        int                                                    ivc;
        s = source_port(p);
        ivc = s * `CC_VCS + v;
        num_next = assigned_ovc_num;
        dest_next = dest_port;
        g[s].assigned[v] = on;
        g[s].assigned_ovc[v] = on ? vc_onehot(v) : '0;
        num_next[ivc] = on ? vc_onehot(v) : '0;
        dest_next[ivc] = on ? dest_onehot(s, p) : '0;
        assigned_ovc_num <= num_next;
        dest_port <= dest_next;
    endtask

    task automatic apply_test(input test_op_e op, input int p, input int v, input int n);
        grant_bus_t                   g;
        credit_counter_pkg::ovc_vec_t ovc_bit;
        credit_counter_pkg::ovc_vec_t ivc_bit;
        int                           s;
        s = source_port(p);
        ovc_bit = '0;
        ovc_bit[p*`CC_VCS + v] = 1'b1;
        ivc_bit = '0;
        ivc_bit[s*`CC_VCS + v] = 1'b1;
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            g = grant;
            case (op)
                op_alloc: begin
                    allocated <= ovc_bit;
                    set_route(p, v, 1'b1, g);
                end
                op_send, op_send_tail: begin
                    sw_grant_ivc <= ivc_bit;
                    g[s].granted_ivc = vc_onehot(v);
                    g[s].granted_dest = dest_onehot(s, p);
                    g[s].tail = (op == op_send_tail) ? vc_onehot(v) : '0;
                end
                op_credit: credit_in <= ovc_bit;
                default: ;
            endcase
            grant <= g;
        end
        @(posedge clk);
        g = grant;
        allocated <= '0;
        credit_in <= '0;
        sw_grant_ivc <= '0;
        g[s].granted_ivc = '0;
        g[s].granted_dest = '0;
        g[s].tail = '0;
        if (op == op_send_tail) begin
            set_route(p, v, 1'b0, g);  // input VC gives up its OVC after the tail
        end
        grant <= g;
    endtask

    initial begin
        string                        line;
        string                        op_name;
        test_op_e                     op;
        int                           p;
        int                           v;
        int                           n;
        int                           fields;
        int                           gap;
        int                           wait_cycles;
        credit_counter_pkg::ovc_vec_t av;
        credit_counter_pkg::ovc_vec_t nf;
        void'($urandom(72222));
        reset = 1'b1;
        grant = '0;
        allocated = '0;
        credit_in = '0;
        sw_grant_ivc = '0;
        assigned_ovc_num = '0;
        dest_port = '0;
        check_req = 1'b0;
        check_id = 0;
        exp_available = '0;
        exp_not_full = '0;
        test_count = 0;
        timed_out = 1'b0;
        bad_pattern = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tests/credit_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tests/credit_patterns.txt");
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%s %d %d %d %h %h", op_name, p, v, n, av, nf);
            if (fields <= 0) continue;  // blank line
            if (fields != 6) begin
                $display("pattern file line has %0d fields instead of 6", fields);
                bad_pattern = 1'b1;
                continue;
            end
            if (!parse_op(op_name, op)) begin
                $display("unknown test operation %s in the pattern file", op_name);
                bad_pattern = 1'b1;
                continue;
            end
            gap = int'($urandom % 4);
            repeat (gap) @(posedge clk);
            apply_test(op, p, v, n);
            repeat (3) @(posedge clk);  // let the 2-cycle path settle
            test_count++;
            check_id <= test_count;
            exp_available <= av;
            exp_not_full <= nf;
            check_req <= 1'b1;
            @(posedge clk);
            check_req <= 1'b0;
            wait_cycles = 0;
            while (checks_done < test_count && wait_cycles < CHECK_TIMEOUT) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (checks_done < test_count) begin
                $display("timeout: the checker gave no result for test %0d in %0d cycles",
                         test_count, CHECK_TIMEOUT);
                timed_out = 1'b1;
            end
        end
        if (fd != 0) $fclose(fd);

        $display("tests: %0d  checked: %0d  errors: %0d", test_count, checks_done, error_count);
        if (fd == 0 || timed_out || bad_pattern || test_count == 0 || error_count != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

// File: tests/credit_patterns.txt
# op         port  vc  count  ovc_available  assigned_ovc_not_full
# vectors in hex, bit = port * 4 + vc; sends come from input port (port + 1) % 5
idle         0     0   1      fffff          fffff
alloc        2     1   1      ffdff          fffff
send         2     1   2      ffdff          fffff
send         2     1   1      ffdff          fdfff
credit       2     1   1      ffdff          fffff
send_tail    2     1   1      ffdff          fffff
credit       2     1   1      ffdff          fffff
credit       2     1   3      fffff          fffff
alloc        0     0   1      ffffe          fffff
alloc        4     3   1      7fffe          fffff
send         4     3   1      7fffe          fffff
send_tail    4     3   1      7fffe          fffff
credit       4     3   1      ffffe          fffff
credit       4     3   2      ffffe          fffff
send         0     0   3      ffffe          fffef
credit       0     0   2      ffffe          fffff
send         0     0   1      ffffe          fffff
send_tail    0     0   1      ffffe          fffff
credit       0     0   4      fffff          fffff
idle         0     0   2      fffff          fffff

// File: credit_counter.f
+incdir+rtl
rtl/credit_counter_pkg.sv
rtl/inport_grant_decode.sv
rtl/ovc_credit_table.sv
rtl/assigned_ovc_full_check.sv
rtl/credit_counter_top.sv
tests/credit_checker.sv
tests/tb_credit_counter.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f credit_counter.f --top-module tb_credit_counter \
    -o tb_credit_counter > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_credit_counter > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
